// File: source/core_pkg.sv
package core_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   // Supported major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      MEM,
      LOAD_WB
   } ctrl_state_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // One fetched word, viewed per instruction format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
   } instr_u;

endpackage

// File: source/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if ();
   import core_pkg::*;

   logic [XLEN-1:0] adr;
   logic [XLEN-1:0] dat;
   logic            we;
   logic            cyc;
   logic [XLEN-1:0] rdt;
   logic            ack;

   // Fetch or load/store side
   modport requester (
      output adr,
      output dat,
      output we,
      output cyc,
      input  rdt,
      input  ack
   );

   modport arbiter (
      input  adr,
      input  dat,
      input  we,
      input  cyc,
      output rdt,
      output ack
   );

endinterface

// File: source/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
   input  logic                      clk,
   input  logic                      i_rst_n,
   mem_bus_if.arbiter                fetch_bus,
   mem_bus_if.arbiter                lsu_bus,
   output logic [core_pkg::XLEN-1:0] o_mem_adr,
   output logic [core_pkg::XLEN-1:0] o_mem_dat,
   output logic                      o_mem_we,
   output logic                      o_mem_cyc,
   input  logic [core_pkg::XLEN-1:0] i_mem_rdt,
   input  logic                      i_mem_ack
);

   logic busy_q;
   logic gnt_lsu_q;
   logic sel_lsu;

   // Fresh decision only when idle, load/store wins
   assign sel_lsu = busy_q ? gnt_lsu_q : lsu_bus.cyc;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy_q    <= 1'b0;
         gnt_lsu_q <= 1'b0;
      end else begin
         busy_q    <= o_mem_cyc && !i_mem_ack;
         gnt_lsu_q <= sel_lsu;
      end
   end

   assign o_mem_adr = sel_lsu ? lsu_bus.adr : fetch_bus.adr;
   assign o_mem_dat = sel_lsu ? lsu_bus.dat : fetch_bus.dat;
   assign o_mem_we  = sel_lsu ? lsu_bus.we  : fetch_bus.we;
   assign o_mem_cyc = sel_lsu ? lsu_bus.cyc : fetch_bus.cyc;

   assign fetch_bus.rdt = i_mem_rdt;
   assign lsu_bus.rdt   = i_mem_rdt;
   assign fetch_bus.ack = i_mem_ack && !sel_lsu;
   assign lsu_bus.ack   = i_mem_ack && sel_lsu;

   // Sequencer keeps one instruction in flight
   assert property (@(posedge clk) disable iff (!i_rst_n)
      !(fetch_bus.cyc && lsu_bus.cyc))
      else $error("fetch and load/store requests overlap");

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic             i_fetch_go,
   output logic             o_instr_valid,
   output core_pkg::instr_u o_instr,
   mem_bus_if.requester     bus
);
   import core_pkg::*;

   logic [XLEN-1:0] pc_q;
   logic            cyc_q;
   logic            fetch_done;

   assign fetch_done = cyc_q && bus.ack;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q          <= RESET_PC;
         cyc_q         <= 1'b0;
         o_instr_valid <= 1'b0;
      end else begin
         o_instr_valid <= fetch_done;
         if (i_fetch_go) begin
            cyc_q <= 1'b1;
         end else if (bus.ack) begin
            cyc_q <= 1'b0;
         end
         // Next PC is ready by the time instr_valid is seen
         if (fetch_done) begin
            pc_q <= pc_q + XLEN'(4);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_done) begin
         o_instr <= bus.rdt;
      end
   end

   assign bus.adr = pc_q;
   assign bus.dat = '0;
   assign bus.we  = 1'b0;
   assign bus.cyc = cyc_q;

endmodule

// File: source/serial_ctrl.sv
`timescale 1ns/10ps

module serial_ctrl (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  logic                        i_instr_valid,
   input  core_pkg::instr_u            i_instr,
   input  logic                        i_mem_done,
   output logic                        o_fetch_go,
   output logic                        o_mem_go,
   output logic [core_pkg::CNT_W-1:0]  o_cnt,
   output logic                        o_exec_en,
   output logic                        o_wb_en,
   output logic [core_pkg::REG_AW-1:0] o_rs1_addr,
   output logic [core_pkg::REG_AW-1:0] o_rs2_addr,
   output logic [core_pkg::REG_AW-1:0] o_rd_addr,
   output logic                        o_rd_wen,
   output logic                        o_rd_from_mem,
   output core_pkg::alu_op_e           o_alu_op,
   output logic                        o_imm_sel,
   output logic                        o_imm_bit,
   output logic                        o_is_load,
   output logic                        o_is_store
);
   import core_pkg::*;

   ctrl_state_e state;
   logic        req_sent;
   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic        is_op;
   logic        is_op_imm;
   logic        alu_wr;
   logic [11:0] imm12;
   logic        last_bit;

   assign opcode     = i_instr.r_fmt.opcode;
   assign funct3     = i_instr.r_fmt.funct3;
   assign is_op      = opcode == OPC_OP;
   assign is_op_imm  = opcode == OPC_OP_IMM;
   assign o_is_load  = opcode == OPC_LOAD;
   assign o_is_store = opcode == OPC_STORE;

   assign o_rs1_addr = i_instr.r_fmt.rs1;
   assign o_rs2_addr = i_instr.r_fmt.rs2;
   assign o_rd_addr  = i_instr.r_fmt.rd;

   always_comb begin
      o_alu_op = ALU_ADD;
      if (is_op) begin
         case (funct3)
            3'b000:  o_alu_op = i_instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
            3'b100:  o_alu_op = ALU_XOR;
            3'b110:  o_alu_op = ALU_OR;
            3'b111:  o_alu_op = ALU_AND;
            default: o_alu_op = ALU_ADD;
         endcase
      end
   end

   // Only ADDI among the immediate forms
   assign alu_wr = (is_op && funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
                   (is_op_imm && funct3 == 3'b000);

   assign o_imm_sel = is_op_imm || o_is_load || o_is_store;
   assign imm12     = o_is_store ? {i_instr.s_fmt.imm_hi, i_instr.s_fmt.imm_lo}
                                 : i_instr.i_fmt.imm;
   // Sign bit repeats above bit 11
   assign o_imm_bit = (o_cnt >= CNT_W'(12)) ? imm12[11] : imm12[o_cnt[3:0]];

   assign o_exec_en     = state == EXEC;
   assign o_wb_en       = state == LOAD_WB;
   assign o_rd_from_mem = o_is_load;
   assign o_rd_wen      = (o_exec_en && alu_wr) || o_wb_en;
   assign o_fetch_go    = (state == FETCH) && !req_sent;
   assign o_mem_go      = (state == MEM) && !req_sent;
   assign last_bit      = &o_cnt;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= FETCH;
         req_sent <= 1'b0;
         o_cnt    <= '0;
      end else begin
         case (state)
            FETCH: begin
               if (o_fetch_go) begin
                  req_sent <= 1'b1;
               end
               if (i_instr_valid) begin
                  req_sent <= 1'b0;
                  state    <= EXEC;
               end
            end
            EXEC: begin
               o_cnt <= o_cnt + CNT_W'(1);
               if (last_bit) begin
                  state <= (o_is_load || o_is_store) ? MEM : FETCH;
               end
            end
            MEM: begin
               if (o_mem_go) begin
                  req_sent <= 1'b1;
               end
               if (i_mem_done) begin
                  req_sent <= 1'b0;
                  state    <= o_is_load ? LOAD_WB : FETCH;
               end
            end
            LOAD_WB: begin
               o_cnt <= o_cnt + CNT_W'(1);
               if (last_bit) begin
                  state <= FETCH;
               end
            end
            default: state <= FETCH;
         endcase
      end
   end

   // Counter wraps to zero at the end of each serial phase and rests there
   assert property (@(posedge clk) disable iff (!i_rst_n)
      !(state inside {EXEC, LOAD_WB}) |-> o_cnt == '0)
      else $error("bit counter not at zero outside EXEC/LOAD_WB");

endmodule

// File: source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
   input  logic                        clk,
   input  logic [core_pkg::REG_AW-1:0] i_rs1_addr,
   input  logic [core_pkg::REG_AW-1:0] i_rs2_addr,
   input  logic [core_pkg::REG_AW-1:0] i_rd_addr,
   input  logic [core_pkg::CNT_W-1:0]  i_cnt,
   input  logic                        i_wen,
   input  logic                        i_rd_bit,
   output logic                        o_rs1_bit,
   output logic                        o_rs2_bit
);
   import core_pkg::*;

   logic [XLEN-1:0] regs [2**REG_AW];

   // x0 reads as zero without ever being stored
   assign o_rs1_bit = (i_rs1_addr != '0) && regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = (i_rs2_addr != '0) && regs[i_rs2_addr][i_cnt];

   // One bit per cycle, same position as the reads
   always_ff @(posedge clk) begin
      if (i_wen && i_rd_addr != '0) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

endmodule

// File: source/serial_alu.sv
`timescale 1ns/10ps

module serial_alu (
   input  logic                       clk,
   input  logic                       i_en,
   input  logic [core_pkg::CNT_W-1:0] i_cnt,
   input  core_pkg::alu_op_e          i_op,
   input  logic                       i_rs1_bit,
   input  logic                       i_rs2_bit,
   input  logic                       i_imm_bit,
   input  logic                       i_imm_sel,
   output logic                       o_rd_bit
);
   import core_pkg::*;

   logic op_b;
   logic sub;
   logic b_eff;
   logic cin;
   logic carry_q;

   assign op_b  = i_imm_sel ? i_imm_bit : i_rs2_bit;
   assign sub   = i_op == ALU_SUB;
   // Subtract as rs1 + ~b + 1
   assign b_eff = op_b ^ sub;
   assign cin   = (i_cnt == '0) ? sub : carry_q;

   always_ff @(posedge clk) begin
      if (i_en) begin
         carry_q <= (i_rs1_bit & b_eff) | (cin & (i_rs1_bit ^ b_eff));
      end
   end

   always_comb begin
      case (i_op)
         ALU_AND: o_rd_bit = i_rs1_bit & op_b;
         ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
         ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
         default: o_rd_bit = i_rs1_bit ^ b_eff ^ cin;
      endcase
   end

endmodule

// File: source/load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
   input  logic         clk,
   input  logic         i_rst_n,
   input  logic         i_exec_en,
   input  logic         i_wb_en,
   input  logic         i_addr_bit,
   input  logic         i_store_bit,
   input  logic         i_is_load,
   input  logic         i_is_store,
   input  logic         i_mem_go,
   output logic         o_mem_done,
   output logic         o_load_bit,
   mem_bus_if.requester bus
);
   import core_pkg::*;

   logic [XLEN-1:0] adr_q;
   logic [XLEN-1:0] dat_q;
   logic            cyc_q;
   logic            mem_op;

   assign mem_op = i_is_load || i_is_store;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cyc_q      <= 1'b0;
         o_mem_done <= 1'b0;
      end else begin
         o_mem_done <= cyc_q && bus.ack;
         if (i_mem_go) begin
            cyc_q <= 1'b1;
         end else if (bus.ack) begin
            cyc_q <= 1'b0;
         end
      end
   end

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (i_exec_en && mem_op) begin
         adr_q <= {i_addr_bit, adr_q[XLEN-1:1]};
         dat_q <= {i_store_bit, dat_q[XLEN-1:1]};
      end else if (cyc_q && bus.ack && i_is_load) begin
         dat_q <= bus.rdt;
      end else if (i_wb_en) begin
         dat_q <= {1'b0, dat_q[XLEN-1:1]};
      end
   end

   assign o_load_bit = dat_q[0];

   // Word access only
   assign bus.adr = {adr_q[XLEN-1:2], 2'b00};
   assign bus.dat = dat_q;
   assign bus.we  = cyc_q && i_is_store;
   assign bus.cyc = cyc_q;

endmodule

// File: source/core_top.sv
`timescale 1ns/10ps

module core_top #(
   parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   output logic [core_pkg::XLEN-1:0] o_mem_adr,
   output logic [core_pkg::XLEN-1:0] o_mem_dat,
   output logic                      o_mem_we,
   output logic                      o_mem_cyc,
   input  logic [core_pkg::XLEN-1:0] i_mem_rdt,
   input  logic                      i_mem_ack
);
   import core_pkg::*;

   logic              fetch_go;
   logic              instr_valid;
   instr_u            instr;
   logic              mem_go;
   logic              mem_done;
   logic [CNT_W-1:0]  cnt;
   logic              exec_en;
   logic              wb_en;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   logic [REG_AW-1:0] rd_addr;
   logic              rd_wen;
   logic              rd_from_mem;
   alu_op_e           alu_op;
   logic              imm_sel;
   logic              imm_bit;
   logic              is_load;
   logic              is_store;
   logic              rs1_bit;
   logic              rs2_bit;
   logic              alu_bit;
   logic              load_bit;
   logic              rd_bit;

   mem_bus_if fetch_bus ();
   mem_bus_if lsu_bus ();

   // Write-back source
   assign rd_bit = rd_from_mem ? load_bit : alu_bit;

   bus_arbiter u_arbiter (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .fetch_bus (fetch_bus.arbiter),
      .lsu_bus   (lsu_bus.arbiter),
      .o_mem_adr (o_mem_adr),
      .o_mem_dat (o_mem_dat),
      .o_mem_we  (o_mem_we),
      .o_mem_cyc (o_mem_cyc),
      .i_mem_rdt (i_mem_rdt),
      .i_mem_ack (i_mem_ack)
   );

   fetch_unit #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_fetch_go    (fetch_go),
      .o_instr_valid (instr_valid),
      .o_instr       (instr),
      .bus           (fetch_bus.requester)
   );

   serial_ctrl u_ctrl (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_instr_valid (instr_valid),
      .i_instr       (instr),
      .i_mem_done    (mem_done),
      .o_fetch_go    (fetch_go),
      .o_mem_go      (mem_go),
      .o_cnt         (cnt),
      .o_exec_en     (exec_en),
      .o_wb_en       (wb_en),
      .o_rs1_addr    (rs1_addr),
      .o_rs2_addr    (rs2_addr),
      .o_rd_addr     (rd_addr),
      .o_rd_wen      (rd_wen),
      .o_rd_from_mem (rd_from_mem),
      .o_alu_op      (alu_op),
      .o_imm_sel     (imm_sel),
      .o_imm_bit     (imm_bit),
      .o_is_load     (is_load),
      .o_is_store    (is_store)
   );

   reg_file u_rf (
      .clk        (clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_cnt      (cnt),
      .i_wen      (rd_wen),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   serial_alu u_alu (
      .clk       (clk),
      .i_en      (exec_en),
      .i_cnt     (cnt),
      .i_op      (alu_op),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .i_imm_sel (imm_sel),
      .o_rd_bit  (alu_bit)
   );

   load_store_unit u_lsu (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_exec_en   (exec_en),
      .i_wb_en     (wb_en),
      .i_addr_bit  (alu_bit),
      .i_store_bit (rs2_bit),
      .i_is_load   (is_load),
      .i_is_store  (is_store),
      .i_mem_go    (mem_go),
      .o_mem_done  (mem_done),
      .o_load_bit  (load_bit),
      .bus         (lsu_bus.requester)
   );

endmodule

// File: test/tb_core_top.sv
`timescale 1ns/10ps

module tb_core_top;

   localparam int MEM_WORDS = 256;
   localparam int MEM_BYTES = MEM_WORDS * 4;

   typedef enum logic [2:0] {
      K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_SW
   } instr_kind_e;

   typedef struct packed {
      instr_kind_e op;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
   } row_t;

   logic        clk;
   logic        i_rst_n;
   logic [31:0] o_mem_adr;
   logic [31:0] o_mem_dat;
   logic        o_mem_we;
   logic        o_mem_cyc;
   logic [31:0] i_mem_rdt;
   logic        i_mem_ack;

   logic [31:0] mem      [MEM_WORDS];
   logic [31:0] ref_mem  [MEM_WORDS];
   logic [31:0] ref_regs [32];
   row_t        prog     [$];
   logic [31:0] exp_adr  [$];
   logic        exp_we   [$];
   logic [31:0] exp_dat  [$];

   integer      seed;
   int          val_errs;
   int          other_errs;
   int          checked;
   int          wait_cnt;
   logic        busy;
   logic        prog_done;
   logic        table_ready;
   logic [31:0] cur_adr;
   logic        cur_we;
   logic [31:0] cur_dat;

   core_top #(
      .RESET_PC (32'h0)
   ) dut (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .o_mem_adr (o_mem_adr),
      .o_mem_dat (o_mem_dat),
      .o_mem_we  (o_mem_we),
      .o_mem_cyc (o_mem_cyc),
      .i_mem_rdt (i_mem_rdt),
      .i_mem_ack (i_mem_ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic add_row(input instr_kind_e op, input int rd, input int rs1, input int rs2,
                          input int imm);
      row_t r;
      r.op  = op;
      r.rd  = rd[4:0];
      r.rs1 = rs1[4:0];
      r.rs2 = rs2[4:0];
      r.imm = imm[11:0];
      prog.push_back(r);
   endtask

   task automatic load_program();
      // x1 points at the data area
      add_row(K_ADDI, 1, 0, 0, 'h200);
      add_row(K_ADDI, 2, 0, 0, 5);
      add_row(K_ADDI, 3, 2, 0, -9);
      add_row(K_SW, 0, 1, 2, 'h180);
      add_row(K_SW, 0, 1, 3, 'h184);
      add_row(K_ADDI, 4, 0, 0, -1);
      add_row(K_ADDI, 5, 0, 0, 1);
      add_row(K_ADD, 6, 4, 5, 0);
      add_row(K_SUB, 7, 0, 5, 0);
      add_row(K_SW, 0, 1, 6, 'h188);
      add_row(K_SW, 0, 1, 7, 'h18c);
      // Random operands from the preloaded words
      add_row(K_LW, 8, 1, 0, 0);
      add_row(K_LW, 9, 1, 0, 4);
      add_row(K_AND, 10, 8, 9, 0);
      add_row(K_OR, 11, 8, 9, 0);
      add_row(K_XOR, 12, 8, 9, 0);
      add_row(K_SW, 0, 1, 10, 'h190);
      add_row(K_SW, 0, 1, 11, 'h194);
      add_row(K_SW, 0, 1, 12, 'h198);
      add_row(K_ADDI, 13, 1, 0, 'h100);
      add_row(K_LW, 14, 13, 0, -16);
      add_row(K_SW, 0, 1, 14, 'h19c);
      // x0 must stay zero
      add_row(K_ADDI, 0, 4, 0, 'h123);
      add_row(K_SW, 0, 1, 0, 'h1a0);
      add_row(K_ADD, 15, 8, 9, 0);
      add_row(K_SUB, 16, 8, 9, 0);
      add_row(K_SW, 0, 1, 15, 'h1a4);
      add_row(K_SW, 0, 1, 16, 'h1a8);
      add_row(K_ADDI, 18, 4, 0, 'h7ff);
      add_row(K_ADDI, 19, 0, 0, -2048);
      add_row(K_SW, 0, 1, 18, 'h1ac);
      add_row(K_SW, 0, 1, 19, 'h1b0);
   endtask

   // RV32I base encodings
   function automatic logic [31:0] encode_instr(row_t r);
      case (r.op)
         K_ADD:   return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
         K_SUB:   return {7'b0100000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
         K_AND:   return {7'b0000000, r.rs2, r.rs1, 3'b111, r.rd, 7'b0110011};
         K_OR:    return {7'b0000000, r.rs2, r.rs1, 3'b110, r.rd, 7'b0110011};
         K_XOR:   return {7'b0000000, r.rs2, r.rs1, 3'b100, r.rd, 7'b0110011};
         K_ADDI:  return {r.imm, r.rs1, 3'b000, r.rd, 7'b0010011};
         K_LW:    return {r.imm, r.rs1, 3'b010, r.rd, 7'b0000011};
         default: return {r.imm[11:5], r.rs2, r.rs1, 3'b010, r.imm[4:0], 7'b0100011};
      endcase
   endfunction

   task automatic push_access(input logic [31:0] adr, input logic we, input logic [31:0] dat);
      exp_adr.push_back(adr);
      exp_we.push_back(we);
      exp_dat.push_back(dat);
   endtask

   // Architectural effect of one row and the bus accesses it causes
   task automatic apply_reference(input row_t r, input logic [31:0] pc);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] simm;
      logic [31:0] ea;
      logic [31:0] res;
      a    = ref_regs[r.rs1];
      b    = ref_regs[r.rs2];
      simm = {{20{r.imm[11]}}, r.imm};
      ea   = a + simm;
      res  = 32'h0;
      push_access(pc, 1'b0, 32'h0);
      case (r.op)
         K_ADD:  res = a + b;
         K_SUB:  res = a - b;
         K_AND:  res = a & b;
         K_OR:   res = a | b;
         K_XOR:  res = a ^ b;
         K_ADDI: res = a + simm;
         K_LW: begin
            push_access({ea[31:2], 2'b00}, 1'b0, 32'h0);
            res = ref_mem[ea[9:2]];
         end
         default: begin
            push_access({ea[31:2], 2'b00}, 1'b1, b);
            ref_mem[ea[9:2]] = b;
         end
      endcase
      if (r.op != K_SW && r.rd != 5'd0) begin
         ref_regs[r.rd] = res;
      end
   endtask

   task automatic check_access();
      logic [31:0] e_adr;
      logic        e_we;
      logic [31:0] e_dat;
      e_adr = exp_adr.pop_front();
      e_we  = exp_we.pop_front();
      e_dat = exp_dat.pop_front();
      checked++;
      if (o_mem_adr !== e_adr) begin
         val_errs++;
         $display("[ERROR] o_mem_adr: expected %h, got %h", e_adr, o_mem_adr);
      end
      if (o_mem_we !== e_we) begin
         val_errs++;
         $display("[ERROR] o_mem_we: expected %h, got %h", e_we, o_mem_we);
      end
      if (e_we && o_mem_dat !== e_dat) begin
         val_errs++;
         $display("[ERROR] o_mem_dat: expected %h, got %h", e_dat, o_mem_dat);
      end
      if (o_mem_adr >= MEM_BYTES) begin
         other_errs++;
         $display("access at %h lies outside the memory model", o_mem_adr);
      end
      // Fetch past the last row ends the program
      if (exp_adr.size() == 0) begin
         prog_done = 1'b1;
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d value, %0d other, %0d bus accesses checked",
               val_errs, other_errs, checked);
      if (val_errs == 0 && other_errs == 0 && prog_done) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   // Memory model with a 1 to 3 cycle ack delay
   always @(negedge clk) begin
      if (!i_rst_n) begin
         busy      = 1'b0;
         i_mem_ack = 1'b0;
      end else if (i_mem_ack) begin
         i_mem_ack = 1'b0;
         busy      = 1'b0;
      end else if (busy) begin
         if (!o_mem_cyc || o_mem_adr !== cur_adr || o_mem_we !== cur_we ||
             o_mem_dat !== cur_dat) begin
            other_errs++;
            $display("request at %h was dropped or changed before ack", cur_adr);
         end
         wait_cnt--;
         if (wait_cnt == 0) begin
            if (o_mem_we) begin
               mem[cur_adr[9:2]] = o_mem_dat;
            end else begin
               i_mem_rdt = mem[cur_adr[9:2]];
            end
            i_mem_ack = 1'b1;
         end
      end else if (o_mem_cyc && !prog_done) begin
         check_access();
         if (!prog_done) begin
            busy     = 1'b1;
            cur_adr  = o_mem_adr;
            cur_we   = o_mem_we;
            cur_dat  = o_mem_dat;
            wait_cnt = 1 + {$random(seed)} % 3;
         end
      end
   end

   initial begin
      int limit;
      wait (table_ready === 1'b1);
      limit = (prog.size() * 100 + 200) * 20;
      #(limit);
      other_errs++;
      $display("timeout: program did not finish within %0d ns", limit);
      finish_run();
   end

   initial begin
      i_rst_n     = 1'b0;
      i_mem_ack   = 1'b0;
      i_mem_rdt   = 32'h0;
      seed        = 17023;
      val_errs    = 0;
      other_errs  = 0;
      checked     = 0;
      busy        = 1'b0;
      prog_done   = 1'b0;
      table_ready = 1'b0;
      cur_adr     = 32'h0;
      cur_we      = 1'b0;
      cur_dat     = 32'h0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i]     = $random(seed);
         ref_mem[i] = mem[i];
      end
      for (int i = 0; i < 32; i++) begin
         ref_regs[i] = 32'h0;
      end
      load_program();
      for (int i = 0; i < prog.size(); i++) begin
         mem[i] = encode_instr(prog[i]);
         apply_reference(prog[i], 32'(4 * i));
      end
      push_access(32'(4 * prog.size()), 1'b0, 32'h0);
      table_ready = 1'b1;
      repeat (2) @(negedge clk);
      if (o_mem_cyc !== 1'b0 || o_mem_we !== 1'b0) begin
         other_errs++;
         $display("bus request active at the end of reset");
      end
      i_rst_n = 1'b1;
      wait (prog_done === 1'b1);
      repeat (2) @(negedge clk);
      finish_run();
   end

endmodule

// File: filelist.f
source/core_pkg.sv
source/mem_bus_if.sv
source/bus_arbiter.sv
source/fetch_unit.sv
source/serial_ctrl.sv
source/reg_file.sv
source/serial_alu.sv
source/load_store_unit.sv
source/core_top.sv
test/tb_core_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_core_top
RTL_TOP    := core_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
